//--- Makefile
TOP := tb_pt2262_encoder
SIM := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): files.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module $(TOP)

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/100ps \
		pt2262_pkg.sv osc_tick_gen.sv symbol_sequencer.sv symbol_waveform.sv \
		pt2262_encoder.sv --top-module pt2262_encoder

clean:
	rm -rf obj_dir sim.log

//--- files.f
pt2262_pkg.sv
osc_tick_gen.sv
symbol_sequencer.sv
symbol_waveform.sv
pt2262_encoder.sv
tb_clock_gen.sv
tb_pt2262_encoder.sv

//--- osc_tick_gen.sv
`timescale 1ns/100ps

// Oscillator tick generator.
// Produces a single clk-cycle enable every osc_div cycles, so the rest of the
// encoder runs entirely on clk and no divided clock ever leaves this block.
module osc_tick_gen #(
    parameter int osc_div = pt2262_pkg::OSC_DIVIDER
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    // A divide of one still needs a one-bit counter.
    localparam int CNT_W = (osc_div > 1) ? $clog2(osc_div) : 1;

    logic [CNT_W-1:0] cnt;  // Cycles left until the next tick.

    // The counter starts full, so the first tick appears osc_div cycles after
    // reset is released, and every reload keeps the period at osc_div cycles.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt  <= CNT_W'(osc_div - 1);
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= CNT_W'(osc_div - 1); // Terminal count reached, reload.
            tick <= 1'b1;                // Registered, so the pulse is exactly one cycle wide.
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

//--- pt2262_encoder.sv
`timescale 1ns/100ps

// PT2262 style encoder top.
// Three stages in a chain. The tick generator paces everything, the
// sequencer picks the symbols of a frame, and the waveform block turns each
// symbol into pulses on cod_o. The frame repeats without a pause.
module pt2262_encoder #(
    parameter int osc_div = pt2262_pkg::OSC_DIVIDER
) (
    input  logic                   clk,
    input  logic                   reset,
    input  pt2262_pkg::code_word_t code,
    output logic                   cod_o,
    output logic                   sync
);

    import pt2262_pkg::*;

    logic         tick;      // One cycle enable per oscillator period.
    symbol_kind_e sym_kind;  // Symbol the sequencer wants sent next.
    logic         sym_done;  // Last tick of the symbol on the wire.

    // Oscillator tick.
    osc_tick_gen #(
        .osc_div (osc_div)
    ) i_osc_tick_gen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    // Frame sequencer.
    symbol_sequencer i_symbol_sequencer (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .code     (code),
        .sym_done (sym_done),
        .sym_kind (sym_kind)
    );

    // Pulse shaping. The outputs come straight from its registers.
    symbol_waveform i_symbol_waveform (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .sym_kind (sym_kind),
        .sym_done (sym_done),
        .cod_o    (cod_o),
        .sync     (sync)
    );

endmodule

//--- pt2262_pkg.sv
package pt2262_pkg;

    // Oscillator divider. With a 3 MHz clk this gives the 12 kHz tick of the encoder chip.
    localparam int OSC_DIVIDER = 250;

    // Frame layout.
    localparam int ADDR_SYMBOLS  = 8;   // Tri-state address symbols A0 to A7.
    localparam int DATA_BITS     = 4;   // Binary data symbols D0 to D3.
    localparam int FRAME_SYMBOLS = ADDR_SYMBOLS + DATA_BITS + 1; // The last one is sync.

    // Pulse widths in oscillator ticks.
    // A data or address bit is two pulse pairs and always sums to 32 ticks.
    localparam int SHORT_TICKS    = 4;
    localparam int LONG_TICKS     = 12;
    localparam int SYNC_LOW_TICKS = 124; // Sync is one short pulse and a long gap.

    // Kind of symbol put on the line.
    typedef enum logic [1:0] {
        SYM_ZERO  = 2'b00,  // Short high, long low, twice.
        SYM_ONE   = 2'b01,  // Long high, short low, twice.
        SYM_FLOAT = 2'b10,  // A zero pulse pair then a one pulse pair.
        SYM_SYNC  = 2'b11   // Frame delimiter.
    } symbol_kind_e;

    // Frame sequencer states.
    // SEQ_LOAD waits for the tick that starts a frame and captures the code word there.
    typedef enum logic {
        SEQ_LOAD = 1'b0,
        SEQ_SEND = 1'b1
    } seq_state_e;

    // Phases of one symbol on the wire.
    // The order matters because the waveform steps through them by incrementing.
    typedef enum logic [1:0] {
        PH_HIGH1 = 2'b00,
        PH_LOW1  = 2'b01,
        PH_HIGH2 = 2'b10,
        PH_LOW2  = 2'b11
    } wave_phase_e;

    // Code word sent in every frame.
    // Bit i of each address field belongs to symbol Ai.
    typedef struct packed {
        logic [ADDR_SYMBOLS-1:0] addr_value;  // Value of each address symbol when not floating.
        logic [ADDR_SYMBOLS-1:0] addr_float;  // A set bit sends F and overrides the value bit.
        logic [DATA_BITS-1:0]    data;        // Data bits, D0 in bit 0.
    } code_word_t;

endpackage

//--- symbol_sequencer.sv
`timescale 1ns/100ps

// Frame sequencer.
// Walks the thirteen symbols of a frame with one index in place of a state
// per symbol. The symbol kind is decoded combinationally from the index and
// the code word, and it only moves on the cycle of sym_done, so it is stable
// on every tick the waveform block might sample.
module symbol_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     tick,
    input  pt2262_pkg::code_word_t   code,
    input  logic                     sym_done,
    output pt2262_pkg::symbol_kind_e sym_kind
);

    import pt2262_pkg::*;

    localparam int IDX_W      = $clog2(FRAME_SYMBOLS);
    localparam int ADDR_SEL_W = $clog2(ADDR_SYMBOLS);
    localparam int DATA_SEL_W = $clog2(DATA_BITS);

    seq_state_e            state;
    logic [IDX_W-1:0]      idx;      // Symbol being sent, 0 is A0 and 12 is sync.
    code_word_t            word_q;   // Code word captured for the current frame.
    code_word_t            word;     // Code word the decoder looks at.
    logic [ADDR_SEL_W-1:0] addr_sel;
    logic [DATA_SEL_W-1:0] data_sel;
    logic                  last_sym;

    // While waiting in SEQ_LOAD the index is zero and A0 is taken from the
    // live input. The tick that starts A0 also captures that same value, so
    // the first symbol and the rest of the frame always agree.
    assign word = (state == SEQ_LOAD) ? code : word_q;

    assign addr_sel = idx[ADDR_SEL_W-1:0];
    assign data_sel = DATA_SEL_W'(idx - IDX_W'(ADDR_SYMBOLS)); // D0 follows A7.
    assign last_sym = (idx == IDX_W'(FRAME_SYMBOLS - 1));

    // Symbol decode. Float has priority over the value bit.
    always_comb begin
        if (idx < IDX_W'(ADDR_SYMBOLS)) begin
            if (word.addr_float[addr_sel]) begin
                sym_kind = SYM_FLOAT;
            end else if (word.addr_value[addr_sel]) begin
                sym_kind = SYM_ONE;
            end else begin
                sym_kind = SYM_ZERO;
            end
        end else if (idx < IDX_W'(ADDR_SYMBOLS + DATA_BITS)) begin
            sym_kind = word.data[data_sel] ? SYM_ONE : SYM_ZERO; // Data bits are never F.
        end else begin
            sym_kind = SYM_SYNC;
        end
    end

    // Frame FSM.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= SEQ_LOAD;
            idx   <= '0;
        end else begin
            case (state)
                SEQ_LOAD: begin
                    // The waveform starts A0 on this tick, so from here on the
                    // captured word is used.
                    if (tick) begin
                        state <= SEQ_SEND;
                    end
                end
                SEQ_SEND: begin
                    if (sym_done) begin
                        if (last_sym) begin
                            state <= SEQ_LOAD; // Sync is over and a new frame begins.
                            idx   <= '0;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= SEQ_LOAD;
                    idx   <= '0;
                end
            endcase
        end
    end

    // Code word capture at frame start.
    always_ff @(posedge clk) begin
        if (state == SEQ_LOAD && tick) begin
            word_q <= code;
        end
    end

endmodule

//--- symbol_waveform.sv
`timescale 1ns/100ps

// Symbol waveform generator.
// Every symbol is sent as up to four phases, high, low, high, low. Each phase
// lasts a number of ticks that depends on the symbol kind. A zero length
// phase is skipped, which is how the two-phase sync symbol is made.
module symbol_waveform (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     tick,
    input  pt2262_pkg::symbol_kind_e sym_kind,
    output logic                     sym_done,
    output logic                     cod_o,
    output logic                     sync
);

    import pt2262_pkg::*;

    localparam int CNT_W = $clog2(SYNC_LOW_TICKS + 1); // Wide enough for the sync gap.

    wave_phase_e      phase;
    wave_phase_e      next_phase;
    logic [CNT_W-1:0] cnt;         // Ticks left in the phase after the current one.
    symbol_kind_e     kind_q;      // Symbol being sent.
    logic             last_phase;
    logic             next_high;

    // Length of one phase of a symbol in ticks.
    function automatic logic [CNT_W-1:0] phase_len(input symbol_kind_e kind,
                                                   input wave_phase_e  ph);
        logic [CNT_W-1:0] len;
        case (kind)
            SYM_ZERO:  len = (ph == PH_HIGH1 || ph == PH_HIGH2) ? CNT_W'(SHORT_TICKS)
                                                                : CNT_W'(LONG_TICKS);
            SYM_ONE:   len = (ph == PH_HIGH1 || ph == PH_HIGH2) ? CNT_W'(LONG_TICKS)
                                                                : CNT_W'(SHORT_TICKS);
            SYM_FLOAT: len = (ph == PH_HIGH1 || ph == PH_LOW2) ? CNT_W'(SHORT_TICKS)
                                                               : CNT_W'(LONG_TICKS);
            default: begin
                case (ph)
                    PH_HIGH1: len = CNT_W'(SHORT_TICKS);
                    PH_LOW1:  len = CNT_W'(SYNC_LOW_TICKS);
                    default:  len = '0; // Sync has no second pulse pair.
                endcase
            end
        endcase
        return len;
    endfunction

    // The symbol ends after LOW2, or after LOW1 when no second pair follows.
    assign last_phase = (phase == PH_LOW2) ||
                        (phase == PH_LOW1 && phase_len(kind_q, PH_HIGH2) == '0);
    assign next_phase = wave_phase_e'(phase + 1'b1);
    assign next_high  = (next_phase == PH_HIGH1 || next_phase == PH_HIGH2);

    // Done on the final tick of the symbol, so the sequencer has a whole tick
    // period to present the next kind before it is sampled.
    assign sym_done = tick && (cnt == CNT_W'(1)) && last_phase;

    // Reset parks the block at the end of a LOW2 phase, so the first tick simply
    // starts a new symbol.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase  <= PH_LOW2;
            cnt    <= '0;
            kind_q <= SYM_ZERO;
            cod_o  <= 1'b0;
            sync   <= 1'b0;
        end else if (tick) begin
            if (cnt != '0) begin
                cnt <= cnt - 1'b1; // Still inside the current phase.
            end else if (last_phase) begin
                kind_q <= sym_kind;             // Start of a new symbol.
                phase  <= PH_HIGH1;
                cnt    <= phase_len(sym_kind, PH_HIGH1) - 1'b1;
                cod_o  <= 1'b1;
                sync   <= (sym_kind == SYM_SYNC);
            end else begin
                phase <= next_phase;
                cnt   <= phase_len(kind_q, next_phase) - 1'b1;
                cod_o <= next_high;
                sync  <= next_high && (kind_q == SYM_SYNC);
            end
        end
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

// Clock and reset source for the testbench.
// Reset starts high and is released on a falling edge after reset_cycles periods.
module tb_clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk; // Free running, 50 percent duty.
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0; // Released away from the rising edge.
    end

endmodule

//--- tb_pt2262_encoder.sv
`timescale 1ns/100ps

// Testbench for the PT2262 style encoder.
// A pulse decoder rebuilds the symbols from cod_o, and a compare process checks each
// decoded frame against the sequence that the reference function derives from the code word.
module tb_pt2262_encoder;

    import pt2262_pkg::*;

    localparam int OSC_DIV        = 4;    // Short ticks keep the run fast.
    localparam int NUM_FRAMES     = 10;
    localparam int FRAME_TICKS    = 512;  // Twelve 32 tick bits and a 128 tick sync.
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_TICKS * OSC_DIV * 6 / 5;
    localparam int SHORT          = 4;    // Pulse widths in ticks.
    localparam int LONG           = 12;
    localparam int SYNC_GAP       = 124;

    typedef logic [2*FRAME_SYMBOLS-1:0] frame_seq_t;  // Two bits per symbol, A0 in the low bits.
    typedef enum logic [1:0] {PAIR_SL, PAIR_LS, PAIR_SYNC, PAIR_BAD} pair_e;

    logic       clk;
    logic       reset;
    code_word_t code;
    logic       cod_o;
    logic       sync;

    int         seed;
    code_word_t exp_words [NUM_FRAMES];  // Word each frame should carry.
    int         exp_count      = 0;
    frame_seq_t got_frames [NUM_FRAMES]; // Frames rebuilt from the wire.
    int         frames_seen    = 0;
    int         frames_checked = 0;
    int         sym_cnt        = 0;      // Symbols decoded so far in the current frame.
    int         edge_errors    = 0;
    int         decode_errors  = 0;
    int         compare_errors = 0;
    int         cycles         = 0;

    // Decoder state.
    logic       prev_cod  = 1'b0;
    logic       seen_high = 1'b0;
    int         high_len  = 0;
    int         low_len   = 0;
    int         sync_high = 0;  // Cycles of the current high pulse with sync set.
    int         pair_half = 0;
    pair_e      first_pair = PAIR_BAD;
    frame_seq_t cur_frame = '0;

    tb_clock_gen #(
        .period       (20),
        .reset_cycles (10)
    ) i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    pt2262_encoder #(
        .osc_div (OSC_DIV)
    ) i_dut (
        .clk   (clk),
        .reset (reset),
        .code  (code),
        .cod_o (cod_o),
        .sync  (sync)
    );

    // Expected frame. Float wins over the value bit, data bits are 0 or 1, sync closes it.
    function automatic frame_seq_t expected_frame(input code_word_t w);
        frame_seq_t   seq;
        symbol_kind_e k;
        seq = '0;
        for (int i = 0; i < 8; i++) begin
            if (w.addr_float[i]) k = SYM_FLOAT;
            else if (w.addr_value[i]) k = SYM_ONE;
            else k = SYM_ZERO;
            seq[2*i +: 2] = k;
        end
        for (int i = 0; i < 4; i++) begin
            seq[2*(8+i) +: 2] = w.data[i] ? SYM_ONE : SYM_ZERO;
        end
        seq[2*12 +: 2] = SYM_SYNC;
        return seq;
    endfunction

    function automatic code_word_t make_word(input logic [7:0] value, input logic [7:0] flt,
                                             input logic [3:0] data);
        code_word_t w;
        w.addr_value = value;
        w.addr_float = flt;
        w.data       = data;
        return w;
    endfunction

    // Widths are in clk cycles and must be whole ticks.
    function automatic pair_e classify_pair(input int hi, input int lo);
        if (hi % OSC_DIV != 0 || lo % OSC_DIV != 0) return PAIR_BAD;
        if (hi / OSC_DIV == SHORT && lo / OSC_DIV == LONG) return PAIR_SL;
        if (hi / OSC_DIV == LONG && lo / OSC_DIV == SHORT) return PAIR_LS;
        if (hi / OSC_DIV == SHORT && lo / OSC_DIV == SYNC_GAP) return PAIR_SYNC;
        return PAIR_BAD;
    endfunction

    // Two pulse pairs make one bit. Long then short followed by short then long is no symbol.
    function automatic symbol_kind_e bit_symbol(input pair_e first, input pair_e second);
        if (first == PAIR_SL && second == PAIR_SL) return SYM_ZERO;
        if (first == PAIR_LS && second == PAIR_LS) return SYM_ONE;
        if (first == PAIR_SL && second == PAIR_LS) return SYM_FLOAT;
        return SYM_SYNC; // Marker that never matches a bit position.
    endfunction

    task automatic decode_pair(input int hi, input int lo, input int shi);
        pair_e        p;
        symbol_kind_e k;
        p = classify_pair(hi, lo);
        assert (p != PAIR_BAD) else begin
            decode_errors++;
            $display("FAIL %0t: pulse of %0d high and %0d low cycles is no valid pair",
                     $time, hi, lo);
        end
        if (p == PAIR_SYNC) begin
            assert (pair_half == 0) else begin
                decode_errors++;
                $display("The sync pulse arrived in the middle of a bit.");
            end
            assert (sym_cnt == 12) else begin
                decode_errors++;
                $display("A frame held %0d symbols before its sync.", sym_cnt);
            end
            assert (shi == hi) else begin
                decode_errors++;
                $display("FAIL %0t: sync high for %0d of %0d cycles", $time, shi, hi);
            end
            cur_frame[2*12 +: 2] = SYM_SYNC;
            if (frames_seen < NUM_FRAMES) got_frames[frames_seen] = cur_frame;
            frames_seen++;
            sym_cnt   = 0;
            pair_half = 0;
            cur_frame = '0;
        end else if (p != PAIR_BAD) begin
            assert (shi == 0) else begin
                decode_errors++;
                $display("FAIL %0t: sync high during symbol %0d", $time, sym_cnt);
            end
            if (pair_half == 0) begin
                first_pair  = p;
                pair_half   = 1;
            end else begin
                pair_half = 0;
                k = bit_symbol(first_pair, p);
                if (sym_cnt < 12) cur_frame[2*sym_cnt +: 2] = k;
                else begin
                    decode_errors++;
                    $display("More than twelve symbols came before a sync.");
                end
                sym_cnt++;
            end
        end else begin
            pair_half = 0; // Resynchronize on the next pulse.
        end
    endtask

    // Pulse decoder. cod_o is stable on the falling edge.
    always @(negedge clk) begin
        if (!reset) begin
            if (cod_o && !prev_cod) begin
                if (seen_high) decode_pair(high_len, low_len, sync_high);
                seen_high = 1'b1;
                high_len  = 0;
                low_len   = 0;
                sync_high = 0;
            end
            if (cod_o) begin
                high_len++;
                if (sync) sync_high++;
            end else if (seen_high) begin
                low_len++;
            end
            assert (cod_o || !sync) else begin
                decode_errors++;
                $display("FAIL %0t: sync high while cod_o is low", $time);
            end
            prev_cod = cod_o;
        end
    end

    // Compare process.
    always @(negedge clk) begin : compare
        frame_seq_t   exp_seq;
        frame_seq_t   got_seq;
        symbol_kind_e e;
        symbol_kind_e g;
        if (frames_checked < frames_seen && frames_checked < NUM_FRAMES) begin
            got_seq = got_frames[frames_checked];
            exp_seq = expected_frame(exp_words[frames_checked]);
            for (int i = 0; i < FRAME_SYMBOLS; i++) begin
                e = symbol_kind_e'(exp_seq[2*i +: 2]);
                g = symbol_kind_e'(got_seq[2*i +: 2]);
                assert (g == e) else begin
                    compare_errors++;
                    $display("FAIL %0t: frame %0d symbol %0d is %s, expected %s",
                             $time, frames_checked, i, g.name(), e.name());
                end
            end
            frames_checked++;
        end
    end

    // Reset state and the delay to the first pulse.
    initial begin : first_edge_check
        int n;
        n = 0;
        @(posedge clk);
        while (reset) begin
            assert (!cod_o && !sync) else begin
                edge_errors++;
                $display("FAIL %0t: output high during reset", $time);
            end
            @(posedge clk);
        end
        do begin
            @(negedge clk);
            n++;
            if (!cod_o) begin
                assert (!sync) else begin
                    edge_errors++;
                    $display("FAIL %0t: sync high before the first tick", $time);
                end
            end
        end while (!cod_o && n <= 4 * OSC_DIV);
        assert (n == OSC_DIV + 1) else begin
            edge_errors++;
            $display("FAIL %0t: first pulse after %0d cycles, expected %0d",
                     $time, n, OSC_DIV + 1);
        end
    end

    task automatic apply_word(input code_word_t w);
        code = w;
        exp_words[exp_count] = w;
        exp_count++;
    endtask

    task automatic random_word(output code_word_t w);
        logic [31:0] r;
        r = $random(seed);
        w = code_word_t'(r[19:0]);
    endtask

    // Waits for a point inside a frame, then moves to the falling edge to drive.
    task automatic wait_mid_frame(input int frame, input int sym);
        while (frames_seen < frame || (frames_seen == frame && sym_cnt < sym)) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic print_summary();
        $display("Errors: reset %0d, decode %0d, compare %0d; frames checked %0d of %0d",
                 edge_errors, decode_errors, compare_errors, frames_checked, NUM_FRAMES);
    endtask

    initial begin : stimulus
        code_word_t w;
        seed = 32'h7235;
        apply_word(make_word(8'h00, 8'h00, 4'h0)); // All zero, latched by the first frame.
        wait_mid_frame(0, 6);
        apply_word(make_word(8'hFF, 8'h00, 4'hF));
        wait_mid_frame(1, 6);
        apply_word(make_word(8'h0F, 8'h55, 4'h6)); // Floats over both value levels.
        wait_mid_frame(2, 6);
        apply_word(make_word(8'h33, 8'hAA, 4'h9));
        wait_mid_frame(3, 3);
        code = make_word(8'h5A, 8'h81, 4'h3); // Overwritten before the frame ends.
        wait_mid_frame(3, 9);
        apply_word(make_word(8'hC3, 8'h18, 4'hA));
        for (int k = 0; k < 5; k++) begin
            wait_mid_frame(4 + k, 6);
            random_word(w);
            apply_word(w);
        end
        while (frames_checked < NUM_FRAMES) @(posedge clk);
        print_summary();
        if (edge_errors + decode_errors + compare_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Run limit.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the encoder did not finish all frames.",
                     cycles);
            print_summary();
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule
